// File: rtl/trace_settings.svh
// Trace observer build settings
`ifndef TRACE_SETTINGS_SVH
`define TRACE_SETTINGS_SVH

// Number of observed cores
`define TRACE_NUM_CORES 2

// Events buffered per core, power of two
`define TRACE_QUEUE_DEPTH 4

// Upper byte of an l.nop instruction word
`define TRACE_NOP_PREFIX 8'h15

// Simulation nop codes in the immediate field
`define TRACE_NOP_EXIT 16'd1
`define TRACE_NOP_REPORT 16'd2
`define TRACE_NOP_PUTC 16'd4

`endif

// File: rtl/trace_pkg.sv
// Trace observer types
`default_nettype none

`include "trace_settings.svh"

package trace_pkg;

   localparam int NUM_CORES = `TRACE_NUM_CORES;
   // At least one bit even for a single core
   localparam int CORE_ID_W = (NUM_CORES > 1) ? $clog2(NUM_CORES) : 1;

   // One retired instruction at writeback
   typedef struct packed {
      logic        valid;
      logic [31:0] pc;
      logic [31:0] insn;
      logic        wben;
      logic [4:0]  wbreg;
      logic [31:0] wbdata;
   } trace_t;

   typedef enum logic [1:0] {
      ev_exit   = 2'd0,
      ev_report = 2'd1,
      ev_putc   = 2'd2
   } event_kind_e;

   // Character view of the payload word
   typedef struct packed {
      logic [23:0] pad;
      logic [7:0]  chr;
   } char_view_t;

   // Payload read as value or as character
   typedef union packed {
      logic [31:0] value;
      char_view_t  ch;
   } payload_u;

   typedef struct packed {
      event_kind_e           kind;
      logic [CORE_ID_W-1:0]  core_id;
      payload_u              payload;
   } event_t;

endpackage

`default_nettype wire

// File: rtl/core_trace_monitor.sv
// Per-core trace monitor
`timescale 1ns/100ps
`default_nettype none

`include "trace_settings.svh"

module core_trace_monitor import trace_pkg::*; #(
   parameter int CORE_ID = 0
) (
   input  logic        clk_i,
   input  logic        rst_i,
   input  trace_t      trace_i,
   output logic        ev_valid_o,
   output event_t      ev_o,
   output logic        exit_o,
   output logic [31:0] exit_code_o
);

   // Shadow of r3
   logic [31:0] r3_q;
   // Core has retired its exit nop
   logic        exited_q;

   logic        rec_valid;
   logic        is_nop;
   logic [15:0] nop_k;
   logic        is_exit;
   logic        is_report;
   logic        is_putc;
   logic        wr_r3;

   logic        ev_valid_q;
   event_t      ev_q;

   // Everything after exit is ignored
   assign rec_valid = trace_i.valid & ~exited_q;

   // l.nop K carries K in the low half
   assign nop_k  = trace_i.insn[15:0];
   assign is_nop = rec_valid && (trace_i.insn[31:24] == `TRACE_NOP_PREFIX);

   assign is_exit   = is_nop && (nop_k == `TRACE_NOP_EXIT);
   assign is_report = is_nop && (nop_k == `TRACE_NOP_REPORT);
   assign is_putc   = is_nop && (nop_k == `TRACE_NOP_PUTC);

   assign wr_r3 = rec_valid && trace_i.wben && (trace_i.wbreg == 5'd3);

   // r3 shadow, follows every writeback to r3
   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         r3_q <= '0;
      end else if (wr_r3) begin
         r3_q <= trace_i.wbdata;
      end
   end

   // Exit latch silences the core
   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         exited_q <= 1'b0;
      end else if (is_exit) begin
         exited_q <= 1'b1;
      end
   end

   // Event strobe, one cycle after the nop record
   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         ev_valid_q <= 1'b0;
      end else begin
         ev_valid_q <= is_exit | is_report | is_putc;
      end
   end

   // Event body, payload is r3 before this record
   always_ff @(posedge clk_i) begin
      if (is_exit || is_report || is_putc) begin
         ev_q.core_id       <= CORE_ID_W'(CORE_ID);
         ev_q.payload.value <= r3_q;
         if (is_exit) begin
            ev_q.kind <= ev_exit;
         end else if (is_report) begin
            ev_q.kind <= ev_report;
         end else begin
            // Consumer takes the character from the low byte
            ev_q.kind <= ev_putc;
         end
      end
   end

   assign ev_valid_o = ev_valid_q;
   assign ev_o       = ev_q;

   // Exit goes straight to the termination unit
   assign exit_o      = is_exit;
   assign exit_code_o = r3_q;

endmodule

`default_nettype wire

// File: rtl/event_queue.sv
// Per-core event FIFO
`timescale 1ns/100ps
`default_nettype none

`include "trace_settings.svh"

module event_queue import trace_pkg::*; (
   input  logic   clk_i,
   input  logic   rst_i,
   input  logic   push_i,
   input  logic   pop_i,
   input  event_t data_i,
   output event_t data_o,
   output logic   not_empty_o,
   output logic   overflow_o
);

   localparam int DEPTH = `TRACE_QUEUE_DEPTH;
   localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

   event_t           mem [DEPTH];
   logic [PTR_W-1:0] wr_ptr_q;
   logic [PTR_W-1:0] rd_ptr_q;
   // One extra bit to tell full from empty
   logic [PTR_W:0]   count_q;
   logic             overflow_q;

   logic full;
   logic do_push;
   logic do_pop;

   assign full        = (count_q == (PTR_W + 1)'(DEPTH));
   assign not_empty_o = (count_q != '0);

   // Full queue drops the push, even with a pop in the same cycle
   assign do_push = push_i & ~full;
   assign do_pop  = pop_i & not_empty_o;

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         wr_ptr_q   <= '0;
         rd_ptr_q   <= '0;
         count_q    <= '0;
         overflow_q <= 1'b0;
      end else begin
         // Pointers wrap naturally, depth is a power of two
         if (do_push) begin
            wr_ptr_q <= wr_ptr_q + 1'b1;
         end
         if (do_pop) begin
            rd_ptr_q <= rd_ptr_q + 1'b1;
         end
         if (do_push && !do_pop) begin
            count_q <= count_q + 1'b1;
         end else if (do_pop && !do_push) begin
            count_q <= count_q - 1'b1;
         end
         // Sticky until reset
         if (push_i && full) begin
            overflow_q <= 1'b1;
         end
      end
   end

   // Storage
   always_ff @(posedge clk_i) begin
      if (do_push) begin
         mem[wr_ptr_q] <= data_i;
      end
   end

   assign data_o     = mem[rd_ptr_q];
   assign overflow_o = overflow_q;

endmodule

`default_nettype wire

// File: rtl/event_arbiter.sv
// Round-robin event merge
`timescale 1ns/100ps
`default_nettype none

`include "trace_settings.svh"

module event_arbiter import trace_pkg::*; (
   input  logic                         clk_i,
   input  logic                         rst_i,
   input  logic [`TRACE_NUM_CORES-1:0]  not_empty_i,
   input  event_t [`TRACE_NUM_CORES-1:0] head_i,
   output logic [`TRACE_NUM_CORES-1:0]  pop_o,
   output logic                         event_valid_o,
   output event_t                       event_o
);

   localparam int N = `TRACE_NUM_CORES;

   // Last granted core
   logic [CORE_ID_W-1:0] last_q;
   logic [CORE_ID_W-1:0] sel;
   logic                 any;

   logic                 event_valid_q;
   event_t               event_q;

   // Search starts just after the last grant
   always_comb begin
      int idx;
      any   = 1'b0;
      sel   = last_q;
      pop_o = '0;
      for (int k = 1; k <= N; k++) begin
         idx = (int'(last_q) + k) % N;
         if (!any && not_empty_i[idx]) begin
            any = 1'b1;
            sel = CORE_ID_W'(idx);
         end
      end
      // Single pop per cycle
      if (any) begin
         pop_o[sel] = 1'b1;
      end
   end

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         // Core 0 goes first after reset
         last_q        <= CORE_ID_W'(N - 1);
         event_valid_q <= 1'b0;
      end else begin
         event_valid_q <= any;
         if (any) begin
            last_q <= sel;
         end
      end
   end

   // Output register for the chosen head
   always_ff @(posedge clk_i) begin
      if (any) begin
         event_q <= head_i[sel];
      end
   end

   assign event_valid_o = event_valid_q;
   assign event_o       = event_q;

endmodule

`default_nettype wire

// File: rtl/termination_unit.sv
// Run termination tracking
`timescale 1ns/100ps
`default_nettype none

`include "trace_settings.svh"

module termination_unit (
   input  logic                                clk_i,
   input  logic                                rst_i,
   input  logic [`TRACE_NUM_CORES-1:0]         exit_i,
   input  logic [`TRACE_NUM_CORES-1:0][31:0]   exit_code_i,
   output logic                                done_o,
   output logic                                fail_o
);

   localparam int N = `TRACE_NUM_CORES;

   logic [N-1:0] exited_q;
   logic         done_q;
   logic         fail_q;
   // Some core exits with a nonzero code this cycle
   logic         bad_exit;

   always_comb begin
      bad_exit = 1'b0;
      for (int i = 0; i < N; i++) begin
         if (exit_i[i] && (exit_code_i[i] != 32'd0)) begin
            bad_exit = 1'b1;
         end
      end
   end

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         exited_q <= '0;
         done_q   <= 1'b0;
         fail_q   <= 1'b0;
      end else begin
         exited_q <= exited_q | exit_i;
         // One cycle behind the last exit flag
         done_q   <= &exited_q;
         if (bad_exit) begin
            fail_q <= 1'b1;
         end
      end
   end

   assign done_o = done_q;
   assign fail_o = fail_q;

endmodule

`default_nettype wire

// File: rtl/trace_observer_top.sv
// Execution trace observer top
`timescale 1ns/100ps
`default_nettype none

`include "trace_settings.svh"

module trace_observer_top import trace_pkg::*; (
   input  logic                          clk_i,
   input  logic                          rst_i,
   input  trace_t [`TRACE_NUM_CORES-1:0] trace_i,
   output logic                          event_valid_o,
   output event_t                        event_o,
   output logic [`TRACE_NUM_CORES-1:0]   overflow_o,
   output logic                          done_o,
   output logic                          fail_o
);

   localparam int N = `TRACE_NUM_CORES;

   // Monitor to queue
   logic [N-1:0]        ev_valid;
   event_t [N-1:0]      ev;
   // Queue to arbiter and back
   logic [N-1:0]        not_empty;
   event_t [N-1:0]      head;
   logic [N-1:0]        pop;
   // Monitor to termination
   logic [N-1:0]        core_exit;
   logic [N-1:0][31:0]  exit_code;

   for (genvar i = 0; i < N; i++) begin : g_core
      core_trace_monitor #(
         .CORE_ID (i)
      ) i_monitor (
         .clk_i       (clk_i),
         .rst_i       (rst_i),
         .trace_i     (trace_i[i]),
         .ev_valid_o  (ev_valid[i]),
         .ev_o        (ev[i]),
         .exit_o      (core_exit[i]),
         .exit_code_o (exit_code[i])
      );

      event_queue i_queue (
         .clk_i       (clk_i),
         .rst_i       (rst_i),
         .push_i      (ev_valid[i]),
         .pop_i       (pop[i]),
         .data_i      (ev[i]),
         .data_o      (head[i]),
         .not_empty_o (not_empty[i]),
         .overflow_o  (overflow_o[i])
      );
   end

   event_arbiter i_arbiter (
      .clk_i         (clk_i),
      .rst_i         (rst_i),
      .not_empty_i   (not_empty),
      .head_i        (head),
      .pop_o         (pop),
      .event_valid_o (event_valid_o),
      .event_o       (event_o)
   );

   termination_unit i_term (
      .clk_i       (clk_i),
      .rst_i       (rst_i),
      .exit_i      (core_exit),
      .exit_code_i (exit_code),
      .done_o      (done_o),
      .fail_o      (fail_o)
   );

endmodule

`default_nettype wire

// File: dv/tb_trace_observer.sv
// Trace observer testbench
`timescale 1ns/100ps
`default_nettype none

`include "trace_settings.svh"

module tb_trace_observer import trace_pkg::*; ();

   localparam int DEPTH       = `TRACE_QUEUE_DEPTH;
   localparam int RAND_CYCLES = 200;
   localparam int PAIR_ROUNDS = 20;
   // Well past queue depth plus two
   localparam int BURST_LEN   = 2 * `TRACE_QUEUE_DEPTH + 2;
   // Driven cycles including reset and drains
   localparam int STIM_CYCLES = 340;
   localparam int CYCLE_LIMIT = 10 * STIM_CYCLES + 200;

   logic                   clk   = 1'b0;
   logic                   rst   = 1'b1;
   trace_t [NUM_CORES-1:0] trace = '0;
   logic                   ev_valid;
   event_t                 ev_out;
   logic [NUM_CORES-1:0]   overflow;
   logic                   done;
   logic                   fail;

   // Stimulus state
   trace_t next_rec [NUM_CORES];
   int     last_nop [NUM_CORES];
   int     stim_cyc  = 0;
   int     cycles    = 0;
   int     err_value = 0;
   int     err_other = 0;

   // Model state
   logic [31:0] r3_m     [NUM_CORES];
   bit          exited_m [NUM_CORES];
   bit          pend_v   [NUM_CORES];
   event_t      pend_ev  [NUM_CORES];
   int          cnt_m    [NUM_CORES];
   bit          ovf_m    [NUM_CORES];
   event_t      exp_q    [NUM_CORES][$];
   int          last_m;
   bit          done_m;
   bit          fail_m;

   trace_observer_top i_dut (
      .clk_i         (clk),
      .rst_i         (rst),
      .trace_i       (trace),
      .event_valid_o (ev_valid),
      .event_o       (ev_out),
      .overflow_o    (overflow),
      .done_o        (done),
      .fail_o        (fail)
   );

   always #50 clk = ~clk;

   // Watchdog
   always @(posedge clk) begin
      cycles++;
      if (cycles >= CYCLE_LIMIT) begin
         $display("Timeout, run went past %0d cycles", CYCLE_LIMIT);
         $display("Test failed");
         $finish;
      end
   end

   // ALU style record, upper byte never a nop prefix
   function automatic trace_t write_rec(logic [4:0] rd, logic [31:0] data, logic wb);
      trace_t r;
      r.valid  = 1'b1;
      r.pc     = $urandom & 32'hffff_fffc;
      r.insn   = 32'he000_0000 | ($urandom & 32'h00ff_ffff);
      r.wben   = wb;
      r.wbreg  = rd;
      r.wbdata = data;
      return r;
   endfunction

   function automatic trace_t nop_rec(logic [15:0] k);
      trace_t r;
      r.valid  = 1'b1;
      r.pc     = $urandom & 32'hffff_fffc;
      r.insn   = {`TRACE_NOP_PREFIX, 8'h00, k};
      r.wben   = 1'b0;
      r.wbreg  = 5'd0;
      r.wbdata = $urandom;
      return r;
   endfunction

   function automatic bit is_event_nop(trace_t r);
      return (r.insn[31:24] == `TRACE_NOP_PREFIX) &&
             ((r.insn[15:0] == `TRACE_NOP_EXIT) ||
              (r.insn[15:0] == `TRACE_NOP_REPORT) ||
              (r.insn[15:0] == `TRACE_NOP_PUTC));
   endfunction

   // Reference event, r3 taken from before the record
   function automatic event_t expected_event(int core, logic [15:0] k, logic [31:0] r3);
      event_t e;
      e.core_id       = CORE_ID_W'(core);
      // Whole r3 for every kind
      e.payload.value = r3;
      if (k == `TRACE_NOP_EXIT) begin
         e.kind = ev_exit;
      end else if (k == `TRACE_NOP_REPORT) begin
         e.kind = ev_report;
      end else begin
         e.kind = ev_putc;
      end
      return e;
   endfunction

   function automatic bit model_idle();
      for (int c = 0; c < NUM_CORES; c++) begin
         if (exp_q[c].size() != 0 || pend_v[c] || cnt_m[c] != 0) begin
            return 1'b0;
         end
      end
      return 1'b1;
   endfunction

   // Model and comparison, all at the rising edge
   always @(posedge clk) begin
      trace_t rec;
      event_t got;
      event_t want;
      int     sel;
      int     idx;
      int     id;
      if (rst) begin
         for (int c = 0; c < NUM_CORES; c++) begin
            r3_m[c]     = '0;
            exited_m[c] = 1'b0;
            pend_v[c]   = 1'b0;
            cnt_m[c]    = 0;
            ovf_m[c]    = 1'b0;
            exp_q[c].delete();
         end
         last_m = NUM_CORES - 1;
         done_m = 1'b0;
         fail_m = 1'b0;
      end else begin
         // Output event against the per-core expectation
         if (ev_valid) begin
            got = ev_out;
            id  = int'(got.core_id);
            if (id >= NUM_CORES) begin
               $display("Event at %0t names core %0d, which does not exist", $time, id);
               err_other++;
            end else begin
               assert (exp_q[id].size() != 0) else begin
                  $display("Core %0d sent an event at %0t with none outstanding", id, $time);
                  err_other++;
               end
               if (exp_q[id].size() != 0) begin
                  want = exp_q[id].pop_front();
                  assert (got == want) else begin
                     $display("ERROR %0t: core %0d kind %0d payload %h, expected kind %0d payload %h",
                              $time, id, got.kind, got.payload.value,
                              want.kind, want.payload.value);
                     err_value++;
                  end
               end
            end
         end
         // Status levels
         assert (done == done_m) else begin
            $display("ERROR %0t: done_o is %0b, expected %0b", $time, done, done_m);
            err_value++;
         end
         assert (fail == fail_m) else begin
            $display("ERROR %0t: fail_o is %0b, expected %0b", $time, fail, fail_m);
            err_value++;
         end
         for (int c = 0; c < NUM_CORES; c++) begin
            assert (overflow[c] == ovf_m[c]) else begin
               $display("ERROR %0t: overflow_o[%0d] is %0b, expected %0b",
                        $time, c, overflow[c], ovf_m[c]);
               err_value++;
            end
         end
         // Round robin grant from occupancy before this edge
         sel = -1;
         for (int k = 1; k <= NUM_CORES; k++) begin
            idx = (last_m + k) % NUM_CORES;
            if (sel < 0 && cnt_m[idx] > 0) begin
               sel = idx;
            end
         end
         // Pushes land one cycle after the record, full drops them
         for (int c = 0; c < NUM_CORES; c++) begin
            if (pend_v[c]) begin
               if (cnt_m[c] == DEPTH) begin
                  ovf_m[c] = 1'b1;
               end else begin
                  exp_q[c].push_back(pend_ev[c]);
                  cnt_m[c]++;
               end
            end
         end
         if (sel >= 0) begin
            cnt_m[sel]--;
            last_m = sel;
         end
         // done follows the exit flags by one cycle
         done_m = 1'b1;
         for (int c = 0; c < NUM_CORES; c++) begin
            if (!exited_m[c]) begin
               done_m = 1'b0;
            end
         end
         // Records seen by the DUT at this edge
         for (int c = 0; c < NUM_CORES; c++) begin
            rec       = trace[c];
            pend_v[c] = 1'b0;
            if (rec.valid && !exited_m[c]) begin
               if (is_event_nop(rec)) begin
                  pend_v[c]  = 1'b1;
                  pend_ev[c] = expected_event(c, rec.insn[15:0], r3_m[c]);
                  if (rec.insn[15:0] == `TRACE_NOP_EXIT) begin
                     exited_m[c] = 1'b1;
                     if (r3_m[c] != 32'd0) begin
                        fail_m = 1'b1;
                     end
                  end
               end
               if (rec.wben && rec.wbreg == 5'd3) begin
                  r3_m[c] = rec.wbdata;
               end
            end
         end
      end
   end

   task automatic apply_cycle();
      @(posedge clk);
      for (int c = 0; c < NUM_CORES; c++) begin
         trace[c] <= next_rec[c];
      end
      stim_cyc++;
   endtask

   task automatic idle_all();
      for (int c = 0; c < NUM_CORES; c++) begin
         next_rec[c] = '0;
      end
   endtask

   // Idle until nothing is left in flight
   task automatic drain();
      idle_all();
      repeat (2) apply_cycle();
      do begin
         @(negedge clk);
      end while (!model_idle());
   endtask

   // Mixed traffic, at most one nop every other cycle per core
   task automatic random_cycle();
      int          pick;
      logic [15:0] k;
      logic [4:0]  rd;
      for (int c = 0; c < NUM_CORES; c++) begin
         pick = int'($urandom % 8);
         case (pick)
            0, 1: next_rec[c] = '0;
            2, 3: next_rec[c] = write_rec(5'd3, $urandom, 1'b1);
            // r3 index without a writeback
            4: next_rec[c] = write_rec(5'd3, $urandom, 1'b0);
            5: begin
               rd = 5'($urandom % 32);
               if (rd == 5'd3) begin
                  rd = 5'd4;
               end
               next_rec[c] = write_rec(rd, $urandom, 1'b1);
            end
            default: begin
               if (stim_cyc - last_nop[c] >= 2) begin
                  case ($urandom % 4)
                     0: k = `TRACE_NOP_REPORT;
                     1: k = `TRACE_NOP_PUTC;
                     2: k = 16'd0;
                     default: k = 16'd3;
                  endcase
                  next_rec[c] = nop_rec(k);
                  last_nop[c] = stim_cyc;
               end else begin
                  next_rec[c] = '0;
               end
            end
         endcase
      end
   endtask

   initial begin
      void'($urandom(32'h40d0af3c));
      for (int c = 0; c < NUM_CORES; c++) begin
         last_nop[c] = -10;
      end
      idle_all();
      repeat (16) @(posedge clk);
      rst <= 1'b0;

      // Quiet outputs after reset
      @(posedge clk);
      @(negedge clk);
      assert (!ev_valid && !done && !fail && overflow == '0) else begin
         $display("Outputs not all low after reset");
         err_other++;
      end

      // Random traffic within queue depth
      for (int i = 0; i < RAND_CYCLES; i++) begin
         random_cycle();
         apply_cycle();
      end
      drain();

      // All cores raise events in the same cycles
      for (int i = 0; i < PAIR_ROUNDS; i++) begin
         for (int c = 0; c < NUM_CORES; c++) begin
            next_rec[c] = write_rec(5'd3, $urandom, 1'b1);
         end
         apply_cycle();
         for (int c = 0; c < NUM_CORES; c++) begin
            next_rec[c] = nop_rec(($urandom % 2) ? `TRACE_NOP_PUTC : `TRACE_NOP_REPORT);
         end
         apply_cycle();
      end
      drain();
      assert (overflow == '0) else begin
         $display("An event queue overflowed under traffic within its depth");
         err_other++;
      end

      // Back to back putc burst from every core
      for (int c = 0; c < NUM_CORES; c++) begin
         next_rec[c] = write_rec(5'd3, $urandom, 1'b1);
      end
      apply_cycle();
      for (int i = 0; i < BURST_LEN; i++) begin
         for (int c = 0; c < NUM_CORES; c++) begin
            next_rec[c] = nop_rec(`TRACE_NOP_PUTC);
         end
         apply_cycle();
      end
      drain();
      assert (overflow != '0) else begin
         $display("A putc burst past the queue depth set no overflow bit");
         err_other++;
      end

      // Core 0 exits clean, then keeps retiring
      idle_all();
      next_rec[0] = write_rec(5'd3, 32'd0, 1'b1);
      next_rec[1] = write_rec(5'd3, $urandom | 32'd1, 1'b1);
      apply_cycle();
      idle_all();
      next_rec[0] = nop_rec(`TRACE_NOP_EXIT);
      apply_cycle();
      for (int i = 0; i < 4; i++) begin
         next_rec[0] = (i % 2 == 0) ? nop_rec(`TRACE_NOP_REPORT)
                                    : write_rec(5'd3, $urandom, 1'b1);
         apply_cycle();
      end
      drain();
      assert (!done && !fail) else begin
         $display("done_o or fail_o came up before every core had exited");
         err_other++;
      end

      // Remaining cores exit with a nonzero code
      for (int c = 1; c < NUM_CORES; c++) begin
         next_rec[c] = nop_rec(`TRACE_NOP_EXIT);
      end
      apply_cycle();
      drain();
      assert (done && fail) else begin
         $display("done_o and fail_o not both high after a nonzero exit");
         err_other++;
      end

      $display("Errors: %0d value, %0d other", err_value, err_other);
      if (err_value + err_other == 0) begin
         $display("Test completed successfully");
      end else begin
         $display("Test failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: flist.f
+incdir+rtl
rtl/trace_pkg.sv
rtl/core_trace_monitor.sv
rtl/event_queue.sv
rtl/event_arbiter.sv
rtl/termination_unit.sv
rtl/trace_observer_top.sv
dv/tb_trace_observer.sv

// File: Makefile
# Verilator build for the trace observer

TOP := tb_trace_observer

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing -f flist.f --top-module $(TOP)

sim:
	verilator --binary --timing -f flist.f --top-module $(TOP) \
		--Mdir obj_dir -o sim_$(TOP)
	@out="$$(./obj_dir/sim_$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Test completed successfully"

clean:
	rm -rf obj_dir
